//--- verif/vga_testdata.txt
// Expected VGA timing and pixel colours, all values hex
// Words 0-2: hsync low clocks, hsync period clocks, blank_n high clocks per line
60 320 280
// Words 3-5: vsync low lines, active lines, lines per frame
2 1e0 20d
// Words 6-7: mid-frame reset, lines after the vsync rise and clocks held
100 4
// Word 8: number of sample points below
14
// Sample points in raster order, one per line: x y r g b
// Top row, both sides of the x split
000 000 e0 00 00
13f 000 e0 00 00
140 000 00 00 c0
27f 000 00 00 c0
// Inside the top quadrants
064 064 e0 00 00
1f4 064 00 00 c0
// Last line above the y split
000 0ef e0 00 00
13f 0ef e0 00 00
140 0ef 00 00 c0
27f 0ef 00 00 c0
// First line below the y split
000 0f0 00 e0 00
13f 0f0 00 e0 00
140 0f0 e0 e0 00
27f 0f0 e0 e0 00
// Inside the bottom quadrants
064 190 00 e0 00
1f4 190 e0 e0 00
// Bottom row
000 1df 00 e0 00
13f 1df 00 e0 00
140 1df e0 e0 00
27f 1df e0 e0 00

//--- list.f
design/vga_pkg.sv
design/checker_fill.sv
design/frame_buffer.sv
design/raster_timing.sv
design/pixel_output.sv
design/vga_top.sv
verif/clock_gen.sv
verif/tb_vga_top.sv

//--- Makefile
# Verilator flow for the VGA frame-buffer testbench

TOP = tb_vga_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into $(LOG), check the result"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	elif ! grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	else \
		echo "Simulation finished without errors"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_vga_top.sv
`timescale 1ns/1ps

module tb_vga_top;

	// Clock, power-on reset and the extra mid-frame pulse
	logic M10k_pll;
	logic por;
	logic ext_reset;
	logic reset;

	// DUT outputs
	vga_pkg::rgb_t rgb;
	logic          hsync;
	logic          vsync;
	logic          blank_n;

	// Testdata words and the sample points unpacked from them
	logic [31:0]   tdata [0:255];
	int            n_points;
	int            px [0:63];
	int            py [0:63];
	vga_pkg::rgb_t pexp [0:63];

	// Scan position rebuilt from the sync edges at the ports
	logic hs_prev;
	logic vs_prev;
	logic hs_rise;
	logic vs_rise;
	int   h_since;
	int   v_since;

	// Clocks in two frames
	int   wait_limit;

	assign reset = por | ext_reset;

	clock_gen u_clk (
		.M10k_pll (M10k_pll),
		.reset    (por)
	);

	vga_top UUT (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync),
		.blank_n  (blank_n)
	);

	//////////////////////////////////////////////////
	// Error handling and compares
	//////////////////////////////////////////////////

	task automatic stop_on_error();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic timed_out(input string what);
		$display("Timed out after two frames waiting for %s", what);
		stop_on_error();
	endtask

	task automatic check_rgb(input string name, input vga_pkg::rgb_t got,
		input vga_pkg::rgb_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input vga_pkg::coord_t got,
		input vga_pkg::coord_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	//////////////////////////////////////////////////
	// Port sampling
	//////////////////////////////////////////////////

	// Outputs settle at the rising edge, read them at the falling one
	task automatic sample();
		@(negedge M10k_pll);
		hs_rise = hsync && !hs_prev;
		vs_rise = vsync && !vs_prev;
		hs_prev = hsync;
		vs_prev = vsync;
		// Clocks since hsync rose
		if (hs_rise) begin
			h_since = 0;
		end else begin
			h_since++;
		end
		// Lines since vsync rose, stepping where the back porch ends
		if (vs_rise) begin
			v_since = 0;
		end else if (h_since == vga_pkg::H_BACK) begin
			v_since++;
		end
		if (!blank_n) begin
			check_rgb("rgb", rgb, '0);
		end
	endtask

	task automatic load_testdata();
		int k;
		$readmemh("verif/vga_testdata.txt", tdata);
		n_points = int'(tdata[8]);
		if (n_points < 1 || n_points > 64) begin
			$display("Testdata file is missing or holds a bad point count");
			stop_on_error();
		end
		// Five words per point from word 9 on
		for (k = 0; k < n_points; k++) begin
			px[k]   = int'(tdata[9 + 5 * k]);
			py[k]   = int'(tdata[10 + 5 * k]);
			pexp[k] = {tdata[11 + 5 * k][7:0], tdata[12 + 5 * k][7:0], tdata[13 + 5 * k][7:0]};
		end
	endtask

	//////////////////////////////////////////////////
	// Timing measurements
	//////////////////////////////////////////////////

	// Reset levels hold until hsync first drops
	task automatic check_idle();
		int n;
		n = 0;
		sample();
		while (hsync) begin
			check_level("vsync", vsync, 1'b1);
			check_level("blank_n", blank_n, 1'b0);
			check_rgb("rgb", rgb, '0);
			n++;
			if (n > wait_limit) begin
				timed_out("the first hsync pulse");
			end
			sample();
		end
	endtask

	// Entered on the first low hsync sample
	task automatic measure_line();
		int low;
		int period;
		low = 1;
		period = 0;
		sample();
		while (!hsync) begin
			low++;
			if (low > wait_limit) begin
				timed_out("hsync to rise");
			end
			sample();
		end
		check_count("hsync low clocks", vga_pkg::coord_t'(low), vga_pkg::coord_t'(tdata[0]));
		do begin
			sample();
			period++;
			if (period > wait_limit) begin
				timed_out("the next hsync rise");
			end
		end while (!hs_rise);
		check_count("hsync period", vga_pkg::coord_t'(period), vga_pkg::coord_t'(tdata[1]));
	endtask

	// Waits for the vsync pulse and counts its lines
	task automatic measure_vsync();
		int n;
		int lines;
		n = 0;
		lines = 0;
		do begin
			sample();
			n++;
			if (n > wait_limit) begin
				timed_out("vsync to fall");
			end
		end while (vsync);
		do begin
			sample();
			n++;
			if (hs_rise) begin
				lines++;
			end
			if (n > wait_limit) begin
				timed_out("vsync to rise");
			end
		end while (!vs_rise);
		check_count("vsync low lines", vga_pkg::coord_t'(lines), vga_pkg::coord_t'(tdata[3]));
	endtask

	// One frame from vsync rise to vsync rise, optionally all black
	task automatic measure_frame(input logic black);
		int n;
		int lines;
		int act_lines;
		int run;
		n = 0;
		lines = 0;
		act_lines = 0;
		run = 0;
		do begin
			sample();
			n++;
			if (n > wait_limit) begin
				timed_out("the end of a frame");
			end
			if (hs_rise) begin
				lines++;
			end
			if (blank_n) begin
				if (run == 0) begin
					act_lines++;
				end
				run++;
				if (black) begin
					check_rgb("rgb", rgb, '0);
				end
			end else if (run != 0) begin
				check_count("blank_n high clocks", vga_pkg::coord_t'(run),
					vga_pkg::coord_t'(tdata[2]));
				run = 0;
			end
		end while (!vs_rise);
		check_count("active lines", vga_pkg::coord_t'(act_lines), vga_pkg::coord_t'(tdata[4]));
		check_count("lines per frame", vga_pkg::coord_t'(lines), vga_pkg::coord_t'(tdata[5]));
	endtask

	//////////////////////////////////////////////////
	// Picture checks
	//////////////////////////////////////////////////

	// Points come in raster order, so only the next one can match
	task automatic check_pattern_frame();
		int n;
		int k;
		int x;
		int y;
		n = 0;
		k = 0;
		do begin
			sample();
			n++;
			if (n > wait_limit) begin
				timed_out("the end of the picture frame");
			end
			x = h_since - vga_pkg::H_BACK;
			y = v_since - vga_pkg::V_BACK;
			if (k < n_points && blank_n && x == px[k] && y == py[k]) begin
				check_rgb($sformatf("rgb at x %0d y %0d", x, y), rgb, pexp[k]);
				k++;
			end
		end while (!vs_rise);
		if (k != n_points) begin
			$display("Only %0d of %0d sample points were shown on screen", k, n_points);
			stop_on_error();
		end
	endtask

	// Reset levels, timing, a black frame and then the picture
	task automatic black_then_pattern();
		check_idle();
		measure_line();
		measure_vsync();
		measure_frame(1'b1);
		check_pattern_frame();
	endtask

	task automatic wait_line(input int line);
		int n;
		n = 0;
		do begin
			sample();
			n++;
			if (n > wait_limit) begin
				timed_out("the mid-frame reset line");
			end
		end while (v_since != line);
	endtask

	task automatic pulse_reset(input int clocks);
		@(posedge M10k_pll);
		ext_reset <= 1'b1;
		repeat (clocks) @(posedge M10k_pll);
		ext_reset <= 1'b0;
		// Sync history restarts with the raster
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		h_since = 0;
		v_since = 0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		ext_reset = 1'b0;
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		hs_rise = 1'b0;
		vs_rise = 1'b0;
		h_since = 0;
		v_since = 0;
		wait_limit = 2 * (vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_PULSE
			+ vga_pkg::H_BACK) * (vga_pkg::V_ACTIVE + vga_pkg::V_FRONT
			+ vga_pkg::V_PULSE + vga_pkg::V_BACK);
		load_testdata();
		// From power-on
		black_then_pattern();
		// Reset partway through the next frame
		wait_line(int'(tdata[6]));
		pulse_reset(int'(tdata[7]));
		black_then_pattern();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- verif/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic M10k_pll,
	output logic reset
);

	// 100 ns period
	initial begin
		M10k_pll = 1'b0;
		forever begin
			#50 M10k_pll = ~M10k_pll;
		end
	end

	// Power-on reset over the first three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge M10k_pll);
		reset <= 1'b0;
	end

endmodule

//--- design/vga_top.sv
`timescale 1ns/1ps

module vga_top (
	input  logic          M10k_pll,
	input  logic          reset,
	output vga_pkg::rgb_t rgb,
	output logic          hsync,
	output logic          vsync,
	output logic          blank_n
);

	// Fill engine to buffer
	vga_pkg::mem_write_t wr;
	logic                fill_done;

	// Scan position and read data
	vga_pkg::scan_t      scan;
	vga_pkg::pixel_t     rd_pixel;

	// Pattern writer
	checker_fill u_fill (
		.M10k_pll  (M10k_pll),
		.reset     (reset),
		.wr        (wr),
		.fill_done (fill_done)
	);

	// Pixel memory, one clock read latency
	frame_buffer u_fb (
		.M10k_pll (M10k_pll),
		.wr       (wr),
		.scan     (scan),
		.rd_pixel (rd_pixel)
	);

	// 640x480 raster
	raster_timing u_timing (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.scan     (scan)
	);

	// Colour expansion and VGA registers
	pixel_output u_out (
		.M10k_pll  (M10k_pll),
		.reset     (reset),
		.scan      (scan),
		.rd_pixel  (rd_pixel),
		.fill_done (fill_done),
		.rgb       (rgb),
		.hsync     (hsync),
		.vsync     (vsync),
		.blank_n   (blank_n)
	);

endmodule

//--- design/pixel_output.sv
`timescale 1ns/1ps

module pixel_output (
	input  logic            M10k_pll,
	input  logic            reset,
	input  vga_pkg::scan_t  scan,
	input  vga_pkg::pixel_t rd_pixel,
	input  logic            fill_done,
	output vga_pkg::rgb_t   rgb,
	output logic            hsync,
	output logic            vsync,
	output logic            blank_n
);

	// Scan bits delayed to match the memory read
	logic act_d;
	logic hs_d;
	logic vs_d;

	// Picture enable, only changes during vsync
	logic frame_ok;

	// Expanded colour for the delayed pixel
	vga_pkg::rgb_t color;

	//////////////////////////////////////////////////
	// Alignment stage
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			act_d <= 1'b0;
			hs_d  <= 1'b1;
			vs_d  <= 1'b1;
		end else begin
			act_d <= scan.active;
			hs_d  <= scan.hsync;
			vs_d  <= scan.vsync;
		end
	end

	// Sampled in the vsync pulse so a frame is either all black or all picture
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			frame_ok <= 1'b0;
		end else if (!scan.vsync) begin
			frame_ok <= fill_done;
		end
	end

	// 3-3-2 bits at the top of each channel
	always_comb begin
		color.r = {rd_pixel[7:5], 5'b0};
		color.g = {rd_pixel[4:2], 5'b0};
		color.b = {rd_pixel[1:0], 6'b0};
		if (!(act_d && frame_ok)) begin
			color = '0;
		end
	end

	//////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			rgb     <= '0;
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			rgb     <= color;
			hsync   <= hs_d;
			vsync   <= vs_d;
			blank_n <= act_d;
		end
	end

	// No picture until the buffer has been filled once
	a_fill_black: assert property (@(posedge M10k_pll) !fill_done |=> (rgb == '0));

endmodule

//--- design/raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
	input  logic           M10k_pll,
	input  logic           reset,
	output vga_pkg::scan_t scan
);

	// Horizontal machine, counts clocks
	vga_pkg::phase_t h_phase;
	vga_pkg::coord_t h_cnt;
	logic            h_end;

	// Vertical machine, counts lines
	vga_pkg::phase_t v_phase;
	vga_pkg::coord_t v_cnt;
	logic            v_end;

	// Last clock of the horizontal back porch
	logic            line_end;

	// Phase order, back porch wraps to active
	function automatic vga_pkg::phase_t next_phase(input vga_pkg::phase_t p);
		case (p)
			vga_pkg::ACTIVE: return vga_pkg::FRONT;
			vga_pkg::FRONT:  return vga_pkg::PULSE;
			vga_pkg::PULSE:  return vga_pkg::BACK;
			default:         return vga_pkg::ACTIVE;
		endcase
	endfunction

	// Final count of each horizontal phase
	function automatic vga_pkg::coord_t h_last(input vga_pkg::phase_t p);
		case (p)
			vga_pkg::ACTIVE: return vga_pkg::coord_t'(vga_pkg::H_ACTIVE - 1);
			vga_pkg::FRONT:  return vga_pkg::coord_t'(vga_pkg::H_FRONT - 1);
			vga_pkg::PULSE:  return vga_pkg::coord_t'(vga_pkg::H_PULSE - 1);
			default:         return vga_pkg::coord_t'(vga_pkg::H_BACK - 1);
		endcase
	endfunction

	// Final count of each vertical phase
	function automatic vga_pkg::coord_t v_last(input vga_pkg::phase_t p);
		case (p)
			vga_pkg::ACTIVE: return vga_pkg::coord_t'(vga_pkg::V_ACTIVE - 1);
			vga_pkg::FRONT:  return vga_pkg::coord_t'(vga_pkg::V_FRONT - 1);
			vga_pkg::PULSE:  return vga_pkg::coord_t'(vga_pkg::V_PULSE - 1);
			default:         return vga_pkg::coord_t'(vga_pkg::V_BACK - 1);
		endcase
	endfunction

	assign h_end    = (h_cnt == h_last(h_phase));
	assign v_end    = (v_cnt == v_last(v_phase));
	assign line_end = (h_phase == vga_pkg::BACK) && h_end;

	//////////////////////////////////////////////////
	// Horizontal
	//////////////////////////////////////////////////

	// 640 + 16 + 96 + 48 = 800 clocks per line
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_phase <= vga_pkg::ACTIVE;
			h_cnt   <= '0;
		end else if (h_end) begin
			h_phase <= next_phase(h_phase);
			h_cnt   <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Vertical
	//////////////////////////////////////////////////

	// Starts in the front porch so the screen is blank
	// until a full vertical blank has gone by
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			v_phase <= vga_pkg::FRONT;
			v_cnt   <= '0;
		end else if (line_end) begin
			if (v_end) begin
				v_phase <= next_phase(v_phase);
				v_cnt   <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Scan outputs
	//////////////////////////////////////////////////

	always_comb begin
		// Coordinates only meaningful while active
		scan.x      = (h_phase == vga_pkg::ACTIVE) ? h_cnt : '0;
		scan.y      = (v_phase == vga_pkg::ACTIVE) ? v_cnt : '0;
		scan.active = (h_phase == vga_pkg::ACTIVE) && (v_phase == vga_pkg::ACTIVE);
		// Negative sync
		scan.hsync  = (h_phase != vga_pkg::PULSE);
		scan.vsync  = (v_phase != vga_pkg::PULSE);
	end

	// Visible position stays inside the frame buffer
	a_active_range: assert property (@(posedge M10k_pll) disable iff (reset)
		scan.active |-> (scan.x < vga_pkg::coord_t'(vga_pkg::H_ACTIVE)
			&& scan.y < vga_pkg::coord_t'(vga_pkg::V_ACTIVE)));

endmodule

//--- design/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
	input  logic                M10k_pll,
	input  vga_pkg::mem_write_t wr,
	input  vga_pkg::scan_t      scan,
	output vga_pkg::pixel_t     rd_pixel
);

	// One 3-3-2 byte per visible pixel
	vga_pkg::pixel_t mem [vga_pkg::FRAME_PIXELS];

	// Read address in raster order
	vga_pkg::addr_t rd_addr;

	// y * 640 + x, zero coordinates outside the active area
	assign rd_addr = vga_pkg::addr_t'(scan.y) * vga_pkg::addr_t'(vga_pkg::H_ACTIVE)
		+ vga_pkg::addr_t'(scan.x);

	// Write port from the fill engine
	always_ff @(posedge M10k_pll) begin
		if (wr.we) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// Registered read
	// Same-address collision returns the old byte
	always_ff @(posedge M10k_pll) begin
		rd_pixel <= mem[rd_addr];
	end

endmodule

//--- design/checker_fill.sv
`timescale 1ns/1ps

module checker_fill (
	input  logic                M10k_pll,
	input  logic                reset,
	output vga_pkg::mem_write_t wr,
	output logic                fill_done
);

	// Sweep position
	vga_pkg::coord_t x_cnt;
	vga_pkg::coord_t y_cnt;
	logic            x_last;
	logic            y_last;

	// Colour for the current position
	vga_pkg::pixel_t color;

	assign x_last = (x_cnt == vga_pkg::coord_t'(vga_pkg::H_ACTIVE - 1));
	assign y_last = (y_cnt == vga_pkg::coord_t'(vga_pkg::V_ACTIVE - 1));

	// Quadrant select
	always_comb begin
		if (x_cnt < vga_pkg::coord_t'(vga_pkg::X_SPLIT)) begin
			if (y_cnt < vga_pkg::coord_t'(vga_pkg::Y_SPLIT)) begin
				color = vga_pkg::COLOR_TOP_LEFT;
			end else begin
				color = vga_pkg::COLOR_BOTTOM_LEFT;
			end
		end else begin
			if (y_cnt < vga_pkg::coord_t'(vga_pkg::Y_SPLIT)) begin
				color = vga_pkg::COLOR_TOP_RIGHT;
			end else begin
				color = vga_pkg::COLOR_BOTTOM_RIGHT;
			end
		end
	end

	// Raster-order sweep, wraps forever
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (x_last) begin
			x_cnt <= '0;
			y_cnt <= y_last ? '0 : y_cnt + 1'b1;
		end else begin
			x_cnt <= x_cnt + 1'b1;
		end
	end

	// Write presented one clock after the counters
	always_ff @(posedge M10k_pll) begin
		wr.addr <= vga_pkg::addr_t'(y_cnt) * vga_pkg::addr_t'(vga_pkg::H_ACTIVE)
			+ vga_pkg::addr_t'(x_cnt);
		wr.data <= color;
		if (reset) begin
			wr.we <= 1'b0;
		end else begin
			wr.we <= 1'b1;
		end
	end

	// Sticky once the last pixel has gone out
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			fill_done <= 1'b0;
		end else if (wr.we && wr.addr == vga_pkg::addr_t'(vga_pkg::FRAME_PIXELS - 1)) begin
			fill_done <= 1'b1;
		end
	end

	// Sweep never leaves the buffer
	a_addr_range: assert property (@(posedge M10k_pll) disable iff (reset)
		wr.we |-> (wr.addr < vga_pkg::addr_t'(vga_pkg::FRAME_PIXELS)));

endmodule

//--- design/vga_pkg.sv
package vga_pkg;

	//////////////////////////////////////////////////
	// Video timing
	//////////////////////////////////////////////////

	// Horizontal phase lengths in clocks
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_PULSE  = 96;
	localparam int H_BACK   = 48;

	// Vertical phase lengths in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_PULSE  = 2;
	localparam int V_BACK   = 33;

	// Buffer depth, one byte per visible pixel
	localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;

	// Quadrant boundaries
	localparam int X_SPLIT = 320;
	localparam int Y_SPLIT = 240;

	//////////////////////////////////////////////////
	// Widths and types
	//////////////////////////////////////////////////

	typedef logic [9:0]  coord_t;
	typedef logic [18:0] addr_t;
	typedef logic [7:0]  pixel_t;
	typedef logic [7:0]  chan_t;

	// 3-3-2 colours, red in the top bits
	localparam pixel_t COLOR_TOP_LEFT     = 8'b111_000_00;
	localparam pixel_t COLOR_BOTTOM_LEFT  = 8'b000_111_00;
	localparam pixel_t COLOR_TOP_RIGHT    = 8'b000_000_11;
	localparam pixel_t COLOR_BOTTOM_RIGHT = 8'b111_111_00;

	// Frame-buffer write port
	typedef struct packed {
		logic   we;
		addr_t  addr;
		pixel_t data;
	} mem_write_t;

	// Scan position and sync levels
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
		logic   hsync;
		logic   vsync;
	} scan_t;

	// Expanded output colour
	typedef struct packed {
		chan_t r;
		chan_t g;
		chan_t b;
	} rgb_t;

	// Shared by the horizontal and vertical machines
	typedef enum logic [1:0] {ACTIVE, FRONT, PULSE, BACK} phase_t;

endpackage
